/* accel_rd_dma.sv */
`default_nettype none

`include "pkt_scan_consts.svh"

module accel_rd_dma (
  input  wire                              clk,
  input  wire                              rst,
  input  wire pkt_scan_pkg::dma_desc_t     desc,
  input  wire                              desc_valid,
  output logic [`PS_ACCEL_COUNT-1:0]       desc_error,
  output logic [`PS_ACCEL_COUNT-1:0]       accel_busy,
  input  wire  [`PS_ACCEL_COUNT-1:0]       accel_stop,
  output logic                             mem_rd_en,
  output logic [`PS_LINE_AW-1:0]           mem_rd_addr,
  input  wire  [`PS_LINE_W-1:0]            mem_rd_data,
  output pkt_scan_pkg::line_beat_t         m_beat,
  output logic [`PS_ACCEL_COUNT-1:0]       m_valid,
  input  wire  [`PS_ACCEL_COUNT-1:0]       m_ready
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_SEND
  } state_t;

  state_t                             state;
  logic [$clog2(`PS_ACCEL_COUNT)-1:0] sel;
  logic [`PS_LINE_AW-1:0]             line_ptr;
  logic [`PS_LEN_W-1:0]               remain;
  logic [2:0]                         beat_user;
  logic                               beat_last;
  logic                               stop_pend;
  logic                               handshake;

  assign handshake   = (state == S_SEND) && m_ready[sel];
  assign mem_rd_en   = (state == S_READ);
  assign mem_rd_addr = line_ptr;

  // Line data comes straight from the memory output register
  assign m_beat = {mem_rd_data, beat_user, beat_last};

  always_comb begin
    accel_busy = '0;
    m_valid    = '0;
    if (state != S_IDLE) begin
      accel_busy[sel] = 1'b1;
    end
    if (state == S_SEND) begin
      m_valid[sel] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_IDLE;
      desc_error <= '0;
      stop_pend  <= 1'b0;
    end else begin
      if (desc_valid && (state != S_IDLE)) begin
        desc_error[desc.accel] <= 1'b1;
      end
      if ((state != S_IDLE) && accel_stop[sel]) begin
        stop_pend <= 1'b1;
      end
      case (state)
        S_IDLE: begin
          if (desc_valid && (desc.len != '0)) begin
            sel       <= desc.accel;
            line_ptr  <= desc.addr;
            remain    <= desc.len;
            stop_pend <= 1'b0;
            state     <= S_READ;
          end
        end
        S_READ: begin
          beat_last <= (remain <= `PS_LEN_W'd8);
          beat_user <= (remain <= `PS_LEN_W'd8) ? remain[2:0] - 3'd1 : 3'd7;
          state     <= S_SEND;
        end
        S_SEND: begin
          if (handshake) begin
            line_ptr <= line_ptr + 1'b1;
            remain   <= remain - `PS_LEN_W'd8;
            // Stop takes effect once the current beat is out
            if (beat_last || stop_pend || accel_stop[sel]) begin
              state <= S_IDLE;
            end else begin
              state <= S_READ;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  a_beat_stable: assert property (
    @(posedge clk) disable iff (rst)
    |(m_valid & ~m_ready) |=> $stable(m_beat)
  );

endmodule

`default_nettype wire

/* accel_width_conv.sv */
`default_nettype none

`include "pkt_scan_consts.svh"

module accel_width_conv (
  input  wire                           clk,
  input  wire                           rst,
  input  wire pkt_scan_pkg::line_beat_t s_beat,
  input  wire                           s_valid,
  output logic                          s_ready,
  output logic [7:0]                    m_data,
  output logic                          m_valid,
  output logic                          m_last
);

  logic [`PS_LINE_W-1:0] shift;
  logic [2:0]            cnt;
  logic                  beat_last;
  logic                  full;

  // Next beat is taken together with the final byte of the current one
  assign s_ready = !full || (cnt == 3'd0);
  assign m_valid = full;
  assign m_data  = shift[7:0];
  assign m_last  = full && beat_last && (cnt == 3'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (s_valid && s_ready) begin
      full <= 1'b1;
    end else if (cnt == 3'd0) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (s_valid && s_ready) begin
      shift     <= s_beat.data;
      cnt       <= s_beat.user;
      beat_last <= s_beat.last;
    end else if (full) begin
      shift <= shift >> 8;
      cnt   <= cnt - 3'd1;
    end
  end

  // Only the final beat of a command may carry fewer than eight bytes
  a_short_beat_is_last: assert property (
    @(posedge clk) disable iff (rst)
    (s_valid && !s_beat.last) |-> (s_beat.user == 3'd7)
  );

endmodule

`default_nettype wire

/* accel_wrap.sv */
`default_nettype none

`include "pkt_scan_consts.svh"

module accel_wrap (
  input  wire                                        clk,
  input  wire                                        rst,
  input  wire                                        io_en,
  input  wire                                        io_wen,
  input  wire  [3:0]                                 io_strb,
  input  wire  [12:0]                                io_addr,
  input  wire  [31:0]                                io_wr_data,
  output logic [31:0]                                io_rd_data,
  output logic                                       io_rd_valid,
  output pkt_scan_pkg::mem_wr_t                      mem_wr,
  output logic                                       mem_wr_en,
  output pkt_scan_pkg::dma_desc_t                    desc,
  output logic                                       desc_valid,
  input  wire  [`PS_ACCEL_COUNT-1:0]                 desc_error,
  input  wire  [`PS_ACCEL_COUNT-1:0]                 accel_busy,
  output logic [`PS_ACCEL_COUNT-1:0]                 accel_stop,
  output logic [`PS_ACCEL_COUNT-1:0]                 accel_init,
  output logic [`PS_STATE_W-1:0]                     state_init,
  input  wire  [`PS_ACCEL_COUNT-1:0][`PS_STATE_W-1:0] accel_state,
  input  wire  [`PS_ACCEL_COUNT-1:0]                 byte_valid,
  input  wire  [`PS_ACCEL_COUNT-1:0]                 byte_last,
  input  wire  [`PS_ACCEL_COUNT-1:0][3:0]            sme_match,
  output logic [31:0]                                ip_addr,
  output logic                                       ip_valid,
  input  wire                                        ip_match,
  input  wire                                        ip_done
);

  logic [`PS_LEN_W-1:0]               cmd_len;
  logic [`PS_LINE_AW-1:0]             cmd_addr;
  logic [31:0]                        ip_addr_q;
  logic [`PS_ACCEL_COUNT-1:0]         status_done;
  logic [`PS_ACCEL_COUNT-1:0]         status_match;
  logic [`PS_ACCEL_COUNT-1:0]         done_err;
  logic [`PS_ACCEL_COUNT-1:0][3:0]    match_word;
  logic [$clog2(`PS_ACCEL_COUNT)-1:0] id;
  logic [5:0]                         reg_off;
  logic                               wr_req;
  logic                               rd_req;
  logic                               stall_q;
  logic                               stall_addr;
  logic                               stall_ok;
  logic [31:0]                        stall_data;
  logic [31:0]                        rd_mux;

  assign id      = io_addr[7:6];
  assign reg_off = {io_addr[5:2], 2'b00};
  assign wr_req  = io_en && io_wen;
  assign rd_req  = io_en && !io_wen;

  // Packet memory writes pass straight through
  assign mem_wr    = {io_addr[10:3], io_addr[2], io_wr_data};
  assign mem_wr_en = wr_req && io_addr[12];

  // Host order to network order
  assign ip_addr = {ip_addr_q[7:0], ip_addr_q[15:8], ip_addr_q[23:16], ip_addr_q[31:24]};

  always_ff @(posedge clk) begin
    desc_valid <= 1'b0;
    accel_init <= '0;
    accel_stop <= '0;
    ip_valid   <= 1'b0;
    if (wr_req && !io_addr[12]) begin
      if (io_addr[11]) begin
        ip_addr_q <= io_wr_data;
        ip_valid  <= 1'b1;
      end else if (!io_addr[10]) begin
        case (reg_off)
          `PS_REG_CTRL: begin
            if (io_strb[0]) begin
              desc_valid     <= io_wr_data[0];
              desc           <= {id, cmd_addr, cmd_len};
              accel_init[id] <= io_wr_data[0];
              accel_stop[id] <= io_wr_data[4];
            end
          end
          `PS_REG_LEN:   cmd_len    <= io_wr_data[`PS_LEN_W-1:0];
          `PS_REG_ADDR:  cmd_addr   <= io_wr_data[`PS_LINE_AW-1:0];
          `PS_REG_STATE: state_init <= io_wr_data[`PS_STATE_W-1:0];
          default: ;
        endcase
      end
    end
    if (rst) begin
      desc_valid <= 1'b0;
      accel_init <= '0;
      accel_stop <= '0;
      ip_valid   <= 1'b0;
    end
  end

  // Status and match accumulation, cleared by init
  always_ff @(posedge clk) begin
    if (rst) begin
      status_done  <= '0;
      status_match <= '0;
      done_err     <= '0;
      match_word   <= '0;
    end else begin
      status_done <= (status_done | (byte_valid & byte_last) | accel_stop) & ~accel_init;
      done_err    <= done_err | (status_done & accel_busy);
      for (int i = 0; i < `PS_ACCEL_COUNT; i++) begin
        status_match[i] <= (status_match[i] | (|sme_match[i])) & ~accel_init[i];
        match_word[i]   <= accel_init[i] ? 4'd0 : (match_word[i] | sme_match[i]);
      end
    end
  end

  always_comb begin
    stall_addr = !io_addr[12] &&
                 (io_addr[11] || (!io_addr[10] && (reg_off == `PS_REG_MATCH)));
    // Results from before a pending start are stale
    if (io_addr[11]) begin
      stall_ok   = ip_done && !ip_valid;
      stall_data = {31'd0, ip_match};
    end else begin
      stall_ok   = (status_done[id] || status_match[id]) && !accel_init[id];
      stall_data = {28'd0, match_word[id]};
    end
  end

  always_comb begin
    rd_mux = '0;
    if (!io_addr[12] && io_addr[10]) begin
      case (reg_off)
        `PS_REG_DONE_MATCH:  rd_mux[`PS_ACCEL_COUNT-1:0] = status_done | status_match;
        `PS_REG_DONE:        rd_mux[`PS_ACCEL_COUNT-1:0] = status_done;
        `PS_REG_MATCHES:     rd_mux[`PS_ACCEL_COUNT-1:0] = status_match;
        `PS_REG_BUSY:        rd_mux[`PS_ACCEL_COUNT-1:0] = accel_busy;
        `PS_REG_CMD_STATE_LO: rd_mux[`PS_STATE_W-1:0] = state_init;
        // upper word of the state, always zero with 24 bits
        `PS_REG_CMD_STATE_HI: rd_mux = '0;
        `PS_REG_DESC_ERR:    rd_mux[`PS_ACCEL_COUNT-1:0] = desc_error;
        `PS_REG_DONE_ERR:    rd_mux[`PS_ACCEL_COUNT-1:0] = done_err;
        default:             rd_mux = '0;
      endcase
    end else if (!io_addr[12]) begin
      case (reg_off)
        `PS_REG_CTRL: begin
          rd_mux[1] = accel_busy[id];
          rd_mux[8] = status_done[id];
          rd_mux[9] = status_match[id];
        end
        `PS_REG_STATE: rd_mux[`PS_STATE_W-1:0] = accel_state[id];
        default:       rd_mux = '0;
      endcase
    end
  end

  // Host holds io_addr steady while a read stalls
  always_ff @(posedge clk) begin
    io_rd_valid <= 1'b0;
    if (stall_q || (rd_req && stall_addr)) begin
      stall_q     <= !stall_ok;
      io_rd_valid <= stall_ok;
      io_rd_data  <= stall_data;
    end else if (rd_req) begin
      io_rd_valid <= 1'b1;
      io_rd_data  <= rd_mux;
    end
    if (rst) begin
      io_rd_valid <= 1'b0;
      stall_q     <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* byte_sme.sv */
`default_nettype none

`include "pkt_scan_consts.svh"

module byte_sme (
  input  wire                     clk,
  input  wire                     rst,
  input  wire  [7:0]              data,
  input  wire                     valid,
  input  wire  [`PS_STATE_W-1:0]  state_in,
  input  wire                     state_load,
  output logic [`PS_STATE_W-1:0]  state_out,
  output logic [3:0]              match
);

  localparam logic [3:0][31:0] PATTERNS = {`PS_PAT3, `PS_PAT2, `PS_PAT1, `PS_PAT0};

  // Last three bytes, oldest on top
  logic [`PS_STATE_W-1:0] hist;
  logic [31:0]            window;

  assign window    = {hist, data};
  assign state_out = hist;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      match[i] = valid && (window == PATTERNS[i]);
    end
  end

  // Loaded history lets a pattern straddle two commands
  always_ff @(posedge clk) begin
    if (rst) begin
      hist <= '0;
    end else if (state_load) begin
      hist <= state_in;
    end else if (valid) begin
      hist <= window[`PS_STATE_W-1:0];
    end
  end

endmodule

`default_nettype wire

/* ip_match.sv */
`default_nettype none

`include "pkt_scan_consts.svh"

module ip_match (
  input  wire        clk,
  input  wire        rst,
  input  wire [31:0] addr,
  input  wire        valid,
  output logic       match,
  output logic       done
);

  localparam logic [`PS_IP_ENTRIES-1:0][31:0] IP_TABLE = {
    `PS_IP7, `PS_IP6, `PS_IP5, `PS_IP4, `PS_IP3, `PS_IP2, `PS_IP1, `PS_IP0
  };

  logic [$clog2(`PS_IP_ENTRIES)-1:0] idx;
  logic [31:0]                       addr_q;
  logic                              running;

  // Entry 0 is checked against the incoming word directly
  always_ff @(posedge clk) begin
    if (rst) begin
      running <= 1'b0;
      match   <= 1'b0;
      done    <= 1'b0;
    end else if (valid) begin
      match   <= (addr == IP_TABLE[0]);
      done    <= (addr == IP_TABLE[0]);
      running <= (addr != IP_TABLE[0]);
    end else if (running) begin
      if (addr_q == IP_TABLE[idx]) begin
        match   <= 1'b1;
        done    <= 1'b1;
        running <= 1'b0;
      end else if (idx == `PS_IP_ENTRIES - 1) begin
        done    <= 1'b1;
        running <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid) begin
      addr_q <= addr;
      idx    <= 1'b1;
    end else if (running) begin
      idx <= idx + 1'b1;
    end
  end

  // Lookup ends within one pass over the table
  a_done_in_time: assert property (
    @(posedge clk) disable iff (rst)
    valid |=> ##[0:`PS_IP_ENTRIES-1] (done || valid)
  );

endmodule

`default_nettype wire

/* pkt_mem.sv */
`default_nettype none

`include "pkt_scan_consts.svh"

module pkt_mem (
  input  wire                        clk,
  input  wire                        rst,
  input  wire pkt_scan_pkg::mem_wr_t wr,
  input  wire                        wr_en,
  input  wire                        rd_en,
  input  wire  [`PS_LINE_AW-1:0]     rd_addr,
  output logic [`PS_LINE_W-1:0]      rd_data
);

  logic [`PS_LINE_W-1:0] mem [`PS_MEM_LINES];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr.line][{wr.half, 5'd0} +: `PS_LINE_W/2] <= wr.data;
    end
    // Read data holds until the next read
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  // Host writes and DMA reads must not meet on one line
  a_no_rw_collision: assert property (
    @(posedge clk) disable iff (rst)
    !(wr_en && rd_en && (wr.line == rd_addr))
  );

endmodule

`default_nettype wire

/* pkt_scan.f */
+incdir+.
pkt_scan_pkg.sv
pkt_mem.sv
accel_rd_dma.sv
accel_width_conv.sv
byte_sme.sv
ip_match.sv
accel_wrap.sv
pkt_scan_top.sv
tb_pkt_scan.sv

/* pkt_scan_consts.svh */
`ifndef PKT_SCAN_CONSTS_SVH
`define PKT_SCAN_CONSTS_SVH

`define PS_ACCEL_COUNT 4
`define PS_LINE_W 64
`define PS_MEM_LINES 256
`define PS_LINE_AW 8
`define PS_LEN_W 12
`define PS_STATE_W 24

// Oldest byte in bits 31:24
`define PS_PAT0 32'h4745_5420
`define PS_PAT1 32'h504f_5354
`define PS_PAT2 32'h4854_5450
`define PS_PAT3 32'hdead_beef

// Network byte order
`define PS_IP_ENTRIES 8
`define PS_IP0 32'hc0a8_0001
`define PS_IP1 32'hc0a8_0102
`define PS_IP2 32'h0a00_0001
`define PS_IP3 32'h0a01_0203
`define PS_IP4 32'hac10_0005
`define PS_IP5 32'h0808_0808
`define PS_IP6 32'h0101_0101
`define PS_IP7 32'h7f00_0001

// Accelerator region
`define PS_REG_CTRL 6'h00
`define PS_REG_LEN 6'h04
`define PS_REG_ADDR 6'h08
`define PS_REG_MATCH 6'h0c
`define PS_REG_STATE 6'h10

// Global region
`define PS_REG_DONE_MATCH 6'h00
`define PS_REG_DONE 6'h04
`define PS_REG_MATCHES 6'h08
`define PS_REG_BUSY 6'h0c
`define PS_REG_CMD_STATE_LO 6'h10
`define PS_REG_CMD_STATE_HI 6'h14
`define PS_REG_DESC_ERR 6'h18
`define PS_REG_DONE_ERR 6'h1c

`endif

/* pkt_scan_pkg.sv */
`default_nettype none

`include "pkt_scan_consts.svh"

package pkt_scan_pkg;

  // One scan command
  typedef struct packed {
    logic [$clog2(`PS_ACCEL_COUNT)-1:0] accel;
    logic [`PS_LINE_AW-1:0]             addr;
    logic [`PS_LEN_W-1:0]               len;
  } dma_desc_t;

  // user holds the valid byte count minus one
  typedef struct packed {
    logic [`PS_LINE_W-1:0]           data;
    logic [$clog2(`PS_LINE_W/8)-1:0] user;
    logic                            last;
  } line_beat_t;

  // Half-line write from the host
  typedef struct packed {
    logic [`PS_LINE_AW-1:0]  line;
    logic                    half;
    logic [`PS_LINE_W/2-1:0] data;
  } mem_wr_t;

endpackage

`default_nettype wire

/* pkt_scan_top.sv */
`default_nettype none

`include "pkt_scan_consts.svh"

module pkt_scan_top (
  input  wire         clk,
  input  wire         rst,
  input  wire         io_en,
  input  wire         io_wen,
  input  wire  [3:0]  io_strb,
  input  wire  [12:0] io_addr,
  input  wire  [31:0] io_wr_data,
  output logic [31:0] io_rd_data,
  output logic        io_rd_valid
);

  import pkt_scan_pkg::*;

  mem_wr_t                                  mem_wr;
  logic                                     mem_wr_en;
  logic                                     mem_rd_en;
  logic [`PS_LINE_AW-1:0]                   mem_rd_addr;
  logic [`PS_LINE_W-1:0]                    mem_rd_data;
  dma_desc_t                                desc;
  logic                                     desc_valid;
  logic [`PS_ACCEL_COUNT-1:0]               desc_error;
  logic [`PS_ACCEL_COUNT-1:0]               accel_busy;
  logic [`PS_ACCEL_COUNT-1:0]               accel_stop;
  logic [`PS_ACCEL_COUNT-1:0]               accel_init;
  logic [`PS_STATE_W-1:0]                   state_init;
  logic [`PS_ACCEL_COUNT-1:0][`PS_STATE_W-1:0] accel_state;
  line_beat_t                               beat;
  logic [`PS_ACCEL_COUNT-1:0]               beat_valid;
  logic [`PS_ACCEL_COUNT-1:0]               beat_ready;
  logic [`PS_ACCEL_COUNT-1:0][7:0]          byte_data;
  logic [`PS_ACCEL_COUNT-1:0]               byte_valid;
  logic [`PS_ACCEL_COUNT-1:0]               byte_last;
  logic [`PS_ACCEL_COUNT-1:0][3:0]          sme_match;
  logic [31:0]                              ip_addr;
  logic                                     ip_valid;
  logic                                     ip_match;
  logic                                     ip_done;

  pkt_mem u_mem (
    .clk(clk), .rst(rst), .wr(mem_wr), .wr_en(mem_wr_en),
    .rd_en(mem_rd_en), .rd_addr(mem_rd_addr), .rd_data(mem_rd_data)
  );

  accel_wrap u_wrap (
    .clk(clk), .rst(rst),
    .io_en(io_en), .io_wen(io_wen), .io_strb(io_strb), .io_addr(io_addr),
    .io_wr_data(io_wr_data), .io_rd_data(io_rd_data), .io_rd_valid(io_rd_valid),
    .mem_wr(mem_wr), .mem_wr_en(mem_wr_en),
    .desc(desc), .desc_valid(desc_valid), .desc_error(desc_error),
    .accel_busy(accel_busy), .accel_stop(accel_stop), .accel_init(accel_init),
    .state_init(state_init), .accel_state(accel_state),
    .byte_valid(byte_valid), .byte_last(byte_last), .sme_match(sme_match),
    .ip_addr(ip_addr), .ip_valid(ip_valid), .ip_match(ip_match), .ip_done(ip_done)
  );

  accel_rd_dma u_dma (
    .clk(clk), .rst(rst),
    .desc(desc), .desc_valid(desc_valid), .desc_error(desc_error),
    .accel_busy(accel_busy), .accel_stop(accel_stop),
    .mem_rd_en(mem_rd_en), .mem_rd_addr(mem_rd_addr), .mem_rd_data(mem_rd_data),
    .m_beat(beat), .m_valid(beat_valid), .m_ready(beat_ready)
  );

  ip_match u_ip (
    .clk(clk), .rst(rst), .addr(ip_addr), .valid(ip_valid),
    .match(ip_match), .done(ip_done)
  );

  // One byte lane and matcher per accelerator, sharing the beat bus
  for (genvar i = 0; i < `PS_ACCEL_COUNT; i++) begin : g_accel
    accel_width_conv u_conv (
      .clk(clk), .rst(rst),
      .s_beat(beat), .s_valid(beat_valid[i]), .s_ready(beat_ready[i]),
      .m_data(byte_data[i]), .m_valid(byte_valid[i]), .m_last(byte_last[i])
    );

    byte_sme u_sme (
      .clk(clk), .rst(rst),
      .data(byte_data[i]), .valid(byte_valid[i]),
      .state_in(state_init), .state_load(accel_init[i]),
      .state_out(accel_state[i]), .match(sme_match[i])
    );
  end

endmodule

`default_nettype wire

/* tb_pkt_scan.sv */
`default_nettype none

`include "pkt_scan_consts.svh"

module tb_pkt_scan;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int LOAD_LINES = 80;
  localparam int READ_LIMIT = 400;
  localparam int POLL_LIMIT = 200;

  logic        clk;
  logic        rst;
  logic        io_en;
  logic        io_wen;
  logic [3:0]  io_strb;
  logic [12:0] io_addr;
  logic [31:0] io_wr_data;
  logic [31:0] io_rd_data;
  logic        io_rd_valid;

  // Expected result of the read in flight
  logic [31:0] exp_data;
  string       exp_name;
  logic        chk_active;
  logic        rd_pending;

  int          err_count;
  int          tests_passed;
  int          tests_failed;
  int          seed;

  logic [7:0]  pkt_bytes [LOAD_LINES*8];
  logic [31:0] patterns [4];
  logic [31:0] ip_table [`PS_IP_ENTRIES];

  pkt_scan_top DUT (
    .clk(clk),
    .rst(rst),
    .io_en(io_en),
    .io_wen(io_wen),
    .io_strb(io_strb),
    .io_addr(io_addr),
    .io_wr_data(io_wr_data),
    .io_rd_data(io_rd_data),
    .io_rd_valid(io_rd_valid)
  );

  always #4 clk = ~clk;

  a_read_data: assert property (
    @(posedge clk) disable iff (rst)
    (io_rd_valid && chk_active) |-> (io_rd_data == exp_data)
  ) else begin
    $display("ERR t=%0t %s expected=%h actual=%h", $time, exp_name, exp_data,
             $sampled(io_rd_data));
    err_count = err_count + 1;
  end

  a_no_stray_valid: assert property (
    @(posedge clk) disable iff (rst)
    io_rd_valid |-> rd_pending
  ) else begin
    $display("Read data valid went high at %0t with no read pending", $time);
    err_count = err_count + 1;
  end

  function automatic logic [12:0] accel_addr(input logic [1:0] id, input logic [5:0] off);
    return {5'd0, id, off};
  endfunction

  function automatic logic [12:0] glob_addr(input logic [5:0] off);
    return {3'b001, 4'd0, off};
  endfunction

  function automatic logic [12:0] mem_addr(input logic [7:0] line, input logic half);
    return {2'b10, line, half, 2'b00};
  endfunction

  function automatic logic [31:0] status_word(input logic busy, input logic done,
                                              input logic match);
    return {22'd0, match, done, 6'd0, busy, 1'b0};
  endfunction

  // Host order is the network word with its bytes reversed
  function automatic logic [31:0] to_host_order(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  function automatic logic in_table(input logic [31:0] w);
    logic hit;
    hit = 1'b0;
    for (int k = 0; k < `PS_IP_ENTRIES; k++) begin
      if (ip_table[k] == w) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic write_reg(input logic [12:0] addr, input logic [31:0] data);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_addr    = addr;
    io_wr_data = data;
    @(posedge clk);
    #1;
    io_en  = 1'b0;
    io_wen = 1'b0;
  endtask

  task automatic read_reg(input logic [12:0] addr, input logic check, input logic [31:0] exp,
                          input string name, output logic [31:0] data);
    int waited;
    waited     = 0;
    exp_data   = exp;
    exp_name   = name;
    chk_active = check;
    rd_pending = 1'b1;
    io_en      = 1'b1;
    io_wen     = 1'b0;
    io_addr    = addr;
    @(posedge clk);
    #1;
    // Address stays put through a stall
    io_en = 1'b0;
    while (!io_rd_valid && waited < READ_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!io_rd_valid) begin
      abort_run($sformatf("Read of %s at address %h never returned", name, addr));
    end
    data = io_rd_data;
    // One more edge so the checker samples this read
    @(posedge clk);
    #1;
    rd_pending = 1'b0;
    chk_active = 1'b0;
  endtask

  task automatic check_reg(input logic [12:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] data;
    read_reg(addr, 1'b1, exp, name, data);
  endtask

  task automatic wait_done(input logic [1:0] id);
    logic [31:0] data;
    int          polls;
    polls = 0;
    read_reg(accel_addr(id, `PS_REG_CTRL), 1'b0, '0, "status", data);
    while (!data[8] && polls < POLL_LIMIT) begin
      read_reg(accel_addr(id, `PS_REG_CTRL), 1'b0, '0, "status", data);
      polls++;
    end
    if (!data[8]) begin
      abort_run($sformatf("Accelerator %0d never reported done", id));
    end
  endtask

  task automatic wait_idle();
    logic [31:0] data;
    int          polls;
    polls = 0;
    read_reg(glob_addr(`PS_REG_BUSY), 1'b0, '0, "busy", data);
    while ((data[3:0] != 4'd0) && polls < POLL_LIMIT) begin
      read_reg(glob_addr(`PS_REG_BUSY), 1'b0, '0, "busy", data);
      polls++;
    end
    if (data[3:0] != 4'd0) begin
      abort_run("The DMA stayed busy after the scan should have ended");
    end
  endtask

  task automatic place_pattern(input int at, input logic [31:0] pat);
    pkt_bytes[at]     = pat[31:24];
    pkt_bytes[at + 1] = pat[23:16];
    pkt_bytes[at + 2] = pat[15:8];
    pkt_bytes[at + 3] = pat[7:0];
  endtask

  task automatic load_memory();
    int base;
    for (int l = 0; l < LOAD_LINES; l++) begin
      for (int h = 0; h < 2; h++) begin
        base = l * 8 + h * 4;
        write_reg(mem_addr(8'(l), 1'(h)), {pkt_bytes[base + 3], pkt_bytes[base + 2],
                                          pkt_bytes[base + 1], pkt_bytes[base]});
      end
    end
  endtask

  // Window is the history plus the new byte, oldest byte on top
  task automatic scan_model(input int start, input int len, input logic [23:0] hist_in,
                            output logic [3:0] mword, output logic [23:0] hist);
    logic [31:0] window;
    hist  = hist_in;
    mword = '0;
    for (int j = 0; j < len; j++) begin
      window = {hist, pkt_bytes[start + j]};
      for (int p = 0; p < 4; p++) begin
        if (window == patterns[p]) begin
          mword[p] = 1'b1;
        end
      end
      hist = window[23:0];
    end
  endtask

  task automatic start_scan(input logic [1:0] id, input int line, input int len,
                            input logic [23:0] state);
    write_reg(accel_addr(id, `PS_REG_LEN), len);
    write_reg(accel_addr(id, `PS_REG_ADDR), line);
    write_reg(accel_addr(id, `PS_REG_STATE), {8'd0, state});
    write_reg(accel_addr(id, `PS_REG_CTRL), 32'h1);
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  task automatic test_reset_values();
    int errs;
    errs = err_count;
    check_reg(glob_addr(`PS_REG_DONE_MATCH), '0, "done or match");
    check_reg(glob_addr(`PS_REG_DONE), '0, "done");
    check_reg(glob_addr(`PS_REG_MATCHES), '0, "match");
    check_reg(glob_addr(`PS_REG_BUSY), '0, "busy");
    check_reg(glob_addr(`PS_REG_DESC_ERR), '0, "descriptor error");
    check_reg(glob_addr(`PS_REG_DONE_ERR), '0, "done error");
    for (int i = 0; i < `PS_ACCEL_COUNT; i++) begin
      check_reg(accel_addr(2'(i), `PS_REG_CTRL), '0, $sformatf("status %0d", i));
    end
    end_test("reset values", errs);
  endtask

  task automatic test_scans();
    logic [3:0]  mword;
    logic [23:0] hist;
    int          errs;
    int          len;
    errs = err_count;
    for (int i = 0; i < `PS_ACCEL_COUNT; i++) begin
      len = 24 + 5 * i;
      scan_model(64 * i, len, 24'h0, mword, hist);
      start_scan(2'(i), 8 * i, len, 24'h0);
      // Stalls until the matcher fires
      check_reg(accel_addr(2'(i), `PS_REG_MATCH), {28'd0, mword}, $sformatf("match word %0d", i));
      wait_done(2'(i));
      check_reg(accel_addr(2'(i), `PS_REG_STATE), {8'd0, hist}, $sformatf("state %0d", i));
      check_reg(accel_addr(2'(i), `PS_REG_CTRL), status_word(1'b0, 1'b1, |mword),
                $sformatf("status %0d", i));
    end
    check_reg(glob_addr(`PS_REG_DONE), 32'hf, "done");
    check_reg(glob_addr(`PS_REG_MATCHES), 32'hf, "match");
    check_reg(glob_addr(`PS_REG_BUSY), '0, "busy");
    end_test("scan on each accelerator", errs);
  endtask

  task automatic test_state_and_tail();
    logic [3:0]  mword;
    logic [23:0] hist;
    logic [23:0] init;
    int          errs;
    errs = err_count;
    init = patterns[1][31:8];
    scan_model(320, 20, init, mword, hist);
    start_scan(2'd2, 40, 20, init);
    check_reg(glob_addr(`PS_REG_CMD_STATE_LO), {8'd0, init}, "command state");
    check_reg(accel_addr(2'd2, `PS_REG_MATCH), {28'd0, mword}, "match word after state load");
    wait_done(2'd2);
    check_reg(accel_addr(2'd2, `PS_REG_MATCH), {28'd0, mword}, "match word past length");
    check_reg(accel_addr(2'd2, `PS_REG_STATE), {8'd0, hist}, "state after short line");
    check_reg(glob_addr(`PS_REG_DONE_ERR), '0, "done error");
    end_test("initial state and tail bytes", errs);
  endtask

  task automatic test_desc_error_and_stop();
    int errs;
    errs = err_count;
    start_scan(2'd1, 48, 64, 24'h0);
    write_reg(accel_addr(2'd3, `PS_REG_CTRL), 32'h1);
    check_reg(glob_addr(`PS_REG_BUSY), 32'h2, "busy during scan");
    write_reg(accel_addr(2'd1, `PS_REG_CTRL), 32'h10);
    wait_done(2'd1);
    wait_idle();
    check_reg(glob_addr(`PS_REG_DESC_ERR), 32'h8, "descriptor error");
    check_reg(glob_addr(`PS_REG_DONE_ERR), 32'h2, "done error");
    check_reg(glob_addr(`PS_REG_DONE), 32'h7, "done after stop");
    end_test("descriptor error and stop", errs);
  endtask

  task automatic test_ip_lookup();
    logic [31:0] miss;
    int          errs;
    errs = err_count;
    for (int k = 0; k < `PS_IP_ENTRIES; k++) begin
      write_reg(13'h800, to_host_order(ip_table[k]));
      check_reg(13'h800, 32'h1, $sformatf("ip lookup entry %0d", k));
      if (k % 2 == 1) begin
        miss = ip_table[k] ^ 32'h0000_0f00;
        write_reg(13'h800, to_host_order(miss));
        check_reg(13'h800, {31'd0, in_table(miss)}, $sformatf("ip lookup miss %0d", k));
      end
    end
    end_test("ip lookup", errs);
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    io_en        = 1'b0;
    io_wen       = 1'b0;
    io_strb      = 4'hf;
    io_addr      = '0;
    io_wr_data   = '0;
    exp_data     = '0;
    exp_name     = "";
    chk_active   = 1'b0;
    rd_pending   = 1'b0;
    err_count    = 0;
    tests_passed = 0;
    tests_failed = 0;
    seed         = 32'h6c06_6196;
    patterns[0]  = `PS_PAT0;
    patterns[1]  = `PS_PAT1;
    patterns[2]  = `PS_PAT2;
    patterns[3]  = `PS_PAT3;
    ip_table[0]  = `PS_IP0;
    ip_table[1]  = `PS_IP1;
    ip_table[2]  = `PS_IP2;
    ip_table[3]  = `PS_IP3;
    ip_table[4]  = `PS_IP4;
    ip_table[5]  = `PS_IP5;
    ip_table[6]  = `PS_IP6;
    ip_table[7]  = `PS_IP7;

    for (int i = 0; i < LOAD_LINES * 8; i++) begin
      pkt_bytes[i] = 8'($random(seed));
    end
    // Per-accelerator scans, patterns crossing line edges for some
    for (int i = 0; i < `PS_ACCEL_COUNT; i++) begin
      place_pattern(64 * i + 3 + 4 * i, patterns[i]);
    end
    // Finishes the loaded state, then a pattern beyond the length
    pkt_bytes[320] = patterns[1][7:0];
    place_pattern(340, patterns[3]);

    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    test_reset_values();
    load_memory();
    test_scans();
    test_state_and_tail();
    test_desc_error_and_stop();
    test_ip_lookup();

    $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
